//--- source/qspim_pkg.sv
`default_nettype none
// ----------------------------------------------------------------------
// Shared widths, field positions and encodings of the wishbone front end
// Flash window when address bit 28 is low, register window when it is high
// Command word layout is fixed at 36 bits as the SPI engine expects
// ----------------------------------------------------------------------

package qspim_pkg;

  // ------------------------------------------------------------------
  // Bus and address fields
  // ------------------------------------------------------------------
  localparam int WB_WIDTH     = 32;
  localparam int MEM_SEL_BIT  = 28;  // 0 flash, 1 registers
  localparam int CS_FIELD_LSB = 20;
  localparam int CS_FIELD_MSB = 27;
  localparam int NUM_CS       = 4;
  localparam int REG_ADDR_LSB = 2;   // Word index into register block
  localparam int REG_ADDR_MSB = 5;

  typedef logic [WB_WIDTH-1:0]                  qspim_word_t;
  typedef logic [CS_FIELD_MSB-CS_FIELD_LSB:0]   qspim_cs_field_t;
  typedef logic [REG_ADDR_MSB-REG_ADDR_LSB:0]   qspim_reg_addr_t;
  typedef logic [WB_WIDTH/8-1:0]                qspim_be_t;

  // ------------------------------------------------------------------
  // Command FIFO word
  // ------------------------------------------------------------------
  localparam int CMD_FIFO_WD = 36;
  localparam int WORD_BYTES  = 4;      // Bytes per response word

  localparam logic SOC_FLAG = 1'b1;    // Start of command
  localparam logic EOC_FLAG = 1'b1;    // End of command
  localparam logic NOC_FLAG = 1'b0;    // Flag not set

  typedef logic [CMD_FIFO_WD-1:0] qspim_cmd_word_t;
  typedef logic [7:0]             qspim_data_cnt_t;

  // Read sequencer states
  typedef enum logic [3:0] {
    ST_IDLE      = 4'd0,
    ST_ADR_PHASE = 4'd1,  // Address word goes out
    ST_CMD_WAIT  = 4'd2,  // Engine has not taken the command yet
    ST_READ_DATA = 4'd3
  } qspim_state_e;

  // SPI phase sequences, C cmd A addr M mode D dummy R read W write
  typedef enum logic [3:0] {
    SEQ_C     = 4'b0000,
    SEQ_CA    = 4'b0001,
    SEQ_CAR   = 4'b0010,
    SEQ_CADR  = 4'b0011,
    SEQ_CAMR  = 4'b0100,
    SEQ_CAMDR = 4'b0101,
    SEQ_CAW   = 4'b0110,
    SEQ_CADW  = 4'b0111
  } qspim_seq_e;

endpackage

`default_nettype wire

//--- source/qspim_wb_front.sv
`timescale 1ns/1ns
`default_nettype none
// ----------------------------------------------------------------------
// Master must hold stb and all request fields until wbd_ack_o
// Nothing is captured while spi_init_done_i is low
// One request at a time, ack is a single cycle pulse with data
// ----------------------------------------------------------------------

module qspim_wb_front (
  input  logic                       mclk,
  input  logic                       rst_n,
  input  logic                       spi_init_done_i,
  input  logic                       wbd_stb_i,
  input  logic                       wbd_we_i,
  input  qspim_pkg::qspim_word_t     wbd_adr_i,
  input  qspim_pkg::qspim_word_t     wbd_dat_i,
  input  qspim_pkg::qspim_be_t       wbd_sel_i,
  input  logic                       mem_ack_i,         // From read sequencer
  input  qspim_pkg::qspim_word_t     mem_rdata_i,
  input  logic                       spim_reg_ack_i,    // From register block
  input  qspim_pkg::qspim_word_t     spim_reg_rdata_i,
  output qspim_pkg::qspim_word_t     wbd_dat_o,
  output logic                       wbd_ack_o,
  output logic                       mem_req_o,
  output logic                       reg_req_o,
  output qspim_pkg::qspim_word_t     req_adr_o,
  output logic                       req_we_o,
  output logic                       spim_reg_req_o,
  output qspim_pkg::qspim_reg_addr_t spim_reg_addr_o,
  output logic                       spim_reg_we_o,
  output qspim_pkg::qspim_be_t       spim_reg_be_o,
  output qspim_pkg::qspim_word_t     spim_reg_wdata_o
);

  logic                   wb_req;     // Captured request valid
  logic                   wb_we;
  qspim_pkg::qspim_word_t wb_adr;
  qspim_pkg::qspim_word_t wb_wdata;
  qspim_pkg::qspim_be_t   wb_be;
  logic                   wb_ack;
  qspim_pkg::qspim_word_t wb_rdata;
  logic                   ack_busy;   // Ack now or last cycle

  assign ack_busy = wb_ack | mem_ack_i | spim_reg_ack_i;

  // ------------------------------------------------------------------
  // Request capture
  // ------------------------------------------------------------------
  always_ff @(posedge mclk) begin
    if (!rst_n) begin
      wb_req <= 1'b0;
    end else if (spi_init_done_i) begin
      wb_req <= wbd_stb_i & ~ack_busy;  // Drop on ack so it is not re-issued
    end
  end

  always_ff @(posedge mclk) begin
    if (spi_init_done_i) begin
      wb_adr   <= wbd_adr_i;
      wb_wdata <= wbd_dat_i;
      wb_be    <= wbd_sel_i;
      wb_we    <= wbd_we_i;
    end
  end

  // Split on the window bit
  assign mem_req_o = wb_req & ~wb_adr[qspim_pkg::MEM_SEL_BIT];
  assign reg_req_o = wb_req &  wb_adr[qspim_pkg::MEM_SEL_BIT];
  assign req_adr_o = wb_adr;
  assign req_we_o  = wb_we;

  assign spim_reg_req_o   = reg_req_o;
  assign spim_reg_addr_o  = wb_adr[qspim_pkg::REG_ADDR_MSB:qspim_pkg::REG_ADDR_LSB];
  assign spim_reg_we_o    = wb_we;
  assign spim_reg_be_o    = wb_be;
  assign spim_reg_wdata_o = wb_wdata;

  // ------------------------------------------------------------------
  // Acknowledge and read data return
  // ------------------------------------------------------------------
  always_ff @(posedge mclk) begin
    if (!rst_n) begin
      wb_ack <= 1'b0;
    end else begin
      wb_ack <= (mem_req_o & mem_ack_i) | (reg_req_o & spim_reg_ack_i);
    end
  end

  always_ff @(posedge mclk) begin
    if (mem_req_o && !wb_we && mem_ack_i) begin
      wb_rdata <= mem_rdata_i;         // Flash word
    end else if (reg_req_o && spim_reg_ack_i) begin
      wb_rdata <= spim_reg_rdata_i;
    end
  end

  assign wbd_ack_o = wb_ack;
  assign wbd_dat_o = wb_rdata;

endmodule

`default_nettype wire

//--- source/qspim_cs_decode.sv
`timescale 1ns/1ns
`default_nettype none
// ----------------------------------------------------------------------
// Chip select from flash address bits 27:20, one address/mask pair each
// Several selects may match at once, nothing here gives priority
// ----------------------------------------------------------------------

module qspim_cs_decode (
  input  logic                       mclk,
  input  logic                       rst_n,
  input  logic                       mem_req_i,
  input  qspim_pkg::qspim_word_t     req_adr_i,
  input  qspim_pkg::qspim_cs_field_t cfg_cs_addr_i  [qspim_pkg::NUM_CS],
  input  qspim_pkg::qspim_cs_field_t cfg_cs_amask_i [qspim_pkg::NUM_CS],
  output logic [qspim_pkg::NUM_CS-1:0] m0_cs_reg_o
);

  qspim_pkg::qspim_cs_field_t          cs_field;
  logic [qspim_pkg::NUM_CS-1:0]        cs_match;

  assign cs_field = req_adr_i[qspim_pkg::CS_FIELD_MSB:qspim_pkg::CS_FIELD_LSB];

  // Mask and compare per select
  always_comb begin
    for (int i = 0; i < qspim_pkg::NUM_CS; i++) begin
      cs_match[i] = ((cs_field & cfg_cs_amask_i[i]) == cfg_cs_addr_i[i]);
    end
  end

  // Held between flash requests
  always_ff @(posedge mclk) begin
    if (!rst_n) begin
      m0_cs_reg_o <= '0;
    end else if (mem_req_i) begin
      m0_cs_reg_o <= cs_match;
    end
  end

endmodule

`default_nettype wire

//--- source/qspim_read_fsm.sv
`timescale 1ns/1ns
`default_nettype none
// ----------------------------------------------------------------------
// Flash read sequencer, one response word per bus request
// Command FIFO must be empty before a new first word is written
// Response FIFO is show-ahead, data is valid at the head before the pop
// ----------------------------------------------------------------------

module qspim_read_fsm (
  input  logic                        mclk,
  input  logic                        rst_n,
  input  logic                        cfg_fsm_reset_i,
  input  logic                        mem_req_i,
  input  qspim_pkg::qspim_word_t      req_adr_i,
  input  logic                        pre_hit_i,       // Word already requested
  input  qspim_pkg::qspim_seq_e       cfg_mem_seq_i,
  input  logic [1:0]                  cfg_addr_cnt_i,
  input  logic [3:0]                  cfg_dummy_cnt_i,
  input  qspim_pkg::qspim_data_cnt_t  cfg_data_cnt_i,
  input  logic [7:0]                  cfg_cmd_reg_i,
  input  logic [7:0]                  cfg_mode_reg_i,
  input  logic                        cmd_fifo_empty_i,
  input  logic                        res_fifo_empty_i,
  input  qspim_pkg::qspim_word_t      res_fifo_rdata_i,
  output logic                        cmd_fifo_wr_o,
  output qspim_pkg::qspim_cmd_word_t  cmd_fifo_wdata_o,
  output logic                        res_fifo_rd_o,
  output logic                        mem_ack_o,
  output qspim_pkg::qspim_word_t      mem_rdata_o
);

  qspim_pkg::qspim_state_e state;
  qspim_pkg::qspim_state_e next_state;

  always_ff @(posedge mclk) begin
    if (!rst_n) begin
      state <= qspim_pkg::ST_IDLE;
    end else if (cfg_fsm_reset_i) begin
      state <= qspim_pkg::ST_IDLE;      // Software abort
    end else begin
      state <= next_state;
    end
  end

  // ------------------------------------------------------------------
  // Next state and FIFO strobes
  // ------------------------------------------------------------------
  always_comb begin
    next_state       = state;
    cmd_fifo_wr_o    = 1'b0;
    cmd_fifo_wdata_o = '0;
    res_fifo_rd_o    = 1'b0;
    mem_ack_o        = 1'b0;
    mem_rdata_o      = '0;
    case (state)
      qspim_pkg::ST_IDLE: begin
        if (mem_req_i && pre_hit_i) begin
          next_state = qspim_pkg::ST_READ_DATA;  // Served from prefetch
        end else if (mem_req_i && cmd_fifo_empty_i) begin
          cmd_fifo_wr_o    = 1'b1;
          cmd_fifo_wdata_o = {qspim_pkg::SOC_FLAG, qspim_pkg::NOC_FLAG, cfg_data_cnt_i,
                              cfg_dummy_cnt_i, cfg_addr_cnt_i, cfg_mem_seq_i,
                              cfg_mode_reg_i, cfg_cmd_reg_i};
          next_state       = qspim_pkg::ST_ADR_PHASE;
        end
      end
      qspim_pkg::ST_ADR_PHASE: begin
        cmd_fifo_wr_o    = 1'b1;                 // Always right after first word
        cmd_fifo_wdata_o = {qspim_pkg::NOC_FLAG, qspim_pkg::EOC_FLAG, 2'b00, req_adr_i};
        next_state       = qspim_pkg::ST_CMD_WAIT;
      end
      qspim_pkg::ST_CMD_WAIT: begin
        // Command taken, so older prefetched words are out of the way
        if (cmd_fifo_empty_i) begin
          next_state = qspim_pkg::ST_READ_DATA;
        end
      end
      qspim_pkg::ST_READ_DATA: begin
        if (!res_fifo_empty_i) begin
          res_fifo_rd_o = 1'b1;
          mem_ack_o     = 1'b1;
          mem_rdata_o   = res_fifo_rdata_i;  // Head word
          next_state    = qspim_pkg::ST_IDLE;
        end
      end
      default: begin
        next_state = qspim_pkg::ST_IDLE;
      end
    endcase
  end

endmodule

`default_nettype wire

//--- source/qspim_prefetch_track.sv
`timescale 1ns/1ns
`default_nettype none
// ----------------------------------------------------------------------
// Tracks words already asked of the flash but not yet popped
// Data count is taken as a multiple of four bytes
// Command write and response pop never fall in the same cycle
// ----------------------------------------------------------------------

module qspim_prefetch_track (
  input  logic                       mclk,
  input  logic                       rst_n,
  input  logic                       cmd_wr_i,
  input  logic                       res_rd_i,
  input  qspim_pkg::qspim_word_t     req_adr_i,
  input  qspim_pkg::qspim_data_cnt_t cfg_data_cnt_i,
  output logic                       pre_hit_o
);

  logic                       pre_val;   // Words left in flight
  qspim_pkg::qspim_data_cnt_t pre_cnt;   // Bytes not yet popped
  qspim_pkg::qspim_word_t     pre_adr;   // Address of the next word

  always_ff @(posedge mclk) begin
    if (!rst_n) begin
      pre_val <= 1'b0;
    end else if (cmd_wr_i) begin
      pre_val <= 1'b1;
    end else if (res_rd_i && pre_cnt == qspim_pkg::qspim_data_cnt_t'(qspim_pkg::WORD_BYTES)) begin
      pre_val <= 1'b0;                   // Last word of the burst
    end
  end

  always_ff @(posedge mclk) begin
    if (cmd_wr_i) begin
      pre_cnt <= cfg_data_cnt_i;
      pre_adr <= req_adr_i;
    end else if (res_rd_i) begin
      pre_cnt <= pre_cnt - qspim_pkg::qspim_data_cnt_t'(qspim_pkg::WORD_BYTES);
      pre_adr <= pre_adr + qspim_pkg::qspim_word_t'(qspim_pkg::WORD_BYTES);
    end
  end

  assign pre_hit_o = pre_val & (req_adr_i == pre_adr);

endmodule

`default_nettype wire

//--- source/qspim_if.sv
`timescale 1ns/1ns
`default_nettype none
// ----------------------------------------------------------------------
// Wishbone front end of the quad-SPI flash controller
// SPI engine, command FIFO and response FIFO are outside this block
// Register block answers with a one-cycle ack
// ----------------------------------------------------------------------

module qspim_if (
  input  logic                         mclk,
  input  logic                         rst_n,
  // Wishbone slave
  input  logic                         wbd_stb_i,
  input  qspim_pkg::qspim_word_t       wbd_adr_i,
  input  logic                         wbd_we_i,
  input  qspim_pkg::qspim_word_t       wbd_dat_i,
  input  qspim_pkg::qspim_be_t         wbd_sel_i,
  output qspim_pkg::qspim_word_t       wbd_dat_o,
  output logic                         wbd_ack_o,
  // Configuration
  input  qspim_pkg::qspim_cs_field_t   cfg_m0_cs_addr_i  [qspim_pkg::NUM_CS],
  input  qspim_pkg::qspim_cs_field_t   cfg_m0_cs_amask_i [qspim_pkg::NUM_CS],
  input  logic                         cfg_fsm_reset_i,
  input  qspim_pkg::qspim_seq_e        cfg_mem_seq_i,
  input  logic [1:0]                   cfg_addr_cnt_i,
  input  logic [3:0]                   cfg_dummy_cnt_i,
  input  qspim_pkg::qspim_data_cnt_t   cfg_data_cnt_i,
  input  logic [7:0]                   cfg_cmd_reg_i,
  input  logic [7:0]                   cfg_mode_reg_i,
  input  logic                         spi_init_done_i,
  output logic [qspim_pkg::NUM_CS-1:0] m0_cs_reg_o,
  // Register block
  output logic                         spim_reg_req_o,
  output qspim_pkg::qspim_reg_addr_t   spim_reg_addr_o,
  output logic                         spim_reg_we_o,
  output qspim_pkg::qspim_be_t         spim_reg_be_o,
  output qspim_pkg::qspim_word_t       spim_reg_wdata_o,
  input  logic                         spim_reg_ack_i,
  input  qspim_pkg::qspim_word_t       spim_reg_rdata_i,
  // Command and response FIFOs
  input  logic                         cmd_fifo_empty_i,
  output logic                         cmd_fifo_wr_o,
  output qspim_pkg::qspim_cmd_word_t   cmd_fifo_wdata_o,
  input  logic                         res_fifo_empty_i,
  output logic                         res_fifo_rd_o,
  input  qspim_pkg::qspim_word_t       res_fifo_rdata_i
);

  logic                   mem_req;
  qspim_pkg::qspim_word_t req_adr;
  logic                   mem_ack;    // Sequencer done, one cycle
  qspim_pkg::qspim_word_t mem_rdata;
  logic                   pre_hit;

  // Register path leaves straight through the spim_reg ports
  qspim_wb_front u_front (
    .mclk, .rst_n, .spi_init_done_i,
    .wbd_stb_i, .wbd_we_i, .wbd_adr_i, .wbd_dat_i, .wbd_sel_i,
    .mem_ack_i      (mem_ack),
    .mem_rdata_i    (mem_rdata),
    .spim_reg_ack_i, .spim_reg_rdata_i,
    .wbd_dat_o, .wbd_ack_o,
    .mem_req_o      (mem_req),
    .reg_req_o      (),
    .req_adr_o      (req_adr),
    .req_we_o       (),
    .spim_reg_req_o, .spim_reg_addr_o, .spim_reg_we_o, .spim_reg_be_o, .spim_reg_wdata_o
  );

  qspim_cs_decode u_cs_decode (
    .mclk, .rst_n,
    .mem_req_i      (mem_req),
    .req_adr_i      (req_adr),
    .cfg_cs_addr_i  (cfg_m0_cs_addr_i),
    .cfg_cs_amask_i (cfg_m0_cs_amask_i),
    .m0_cs_reg_o
  );

  qspim_read_fsm u_read_fsm (
    .mclk, .rst_n, .cfg_fsm_reset_i,
    .mem_req_i      (mem_req),
    .req_adr_i      (req_adr),
    .pre_hit_i      (pre_hit),
    .cfg_mem_seq_i, .cfg_addr_cnt_i, .cfg_dummy_cnt_i, .cfg_data_cnt_i,
    .cfg_cmd_reg_i, .cfg_mode_reg_i,
    .cmd_fifo_empty_i, .res_fifo_empty_i, .res_fifo_rdata_i,
    .cmd_fifo_wr_o, .cmd_fifo_wdata_o, .res_fifo_rd_o,
    .mem_ack_o      (mem_ack),
    .mem_rdata_o    (mem_rdata)
  );

  // Tracker follows the FIFO strobes
  qspim_prefetch_track u_prefetch (
    .mclk, .rst_n,
    .cmd_wr_i       (cmd_fifo_wr_o),
    .res_rd_i       (res_fifo_rd_o),
    .req_adr_i      (req_adr),
    .cfg_data_cnt_i,
    .pre_hit_o      (pre_hit)
  );

endmodule

`default_nettype wire

//--- tests/qspim_fifo_model.sv
`timescale 1ns/1ns
`default_nettype none
// ----------------------------------------------------------------------
// Command FIFO reads busy for 3 cycles after each write
// Address word pushes data count/4 words of address XOR 5A5A_0000
// ----------------------------------------------------------------------

module qspim_fifo_model (
  input  logic                       mclk,
  input  logic                       cmd_wr_i,
  input  qspim_pkg::qspim_cmd_word_t cmd_wdata_i,
  input  logic                       res_rd_i,
  output logic                       cmd_empty_o,
  output logic                       res_empty_o,
  output qspim_pkg::qspim_word_t     res_head_o,
  output int                         cmd_cnt_o,    // Command words seen
  output qspim_pkg::qspim_cmd_word_t first_word_o,
  output qspim_pkg::qspim_cmd_word_t adr_word_o
);

  qspim_pkg::qspim_word_t mem [64];
  int busy = 0;
  int wptr = 0;
  int rptr = 0;

  initial cmd_cnt_o = 0;

  always @(posedge mclk) begin
    if (cmd_wr_i) begin
      cmd_cnt_o <= cmd_cnt_o + 1;
      busy      <= 3;
      if (cmd_wdata_i[35]) begin
        first_word_o <= cmd_wdata_i;
      end else begin
        adr_word_o <= cmd_wdata_i;
        for (int i = 0; i < first_word_o[33:26] / 4; i++) begin  // Burst of words
          mem[(wptr + i) % 64] = (cmd_wdata_i[31:0] + 4 * i) ^ 32'h5A5A_0000;
        end
        wptr <= wptr + first_word_o[33:26] / 4;
      end
    end else if (busy > 0) begin
      busy <= busy - 1;
    end
    if (res_rd_i) rptr <= rptr + 1;
  end

  assign cmd_empty_o = (busy == 0);
  assign res_empty_o = (wptr == rptr);
  assign res_head_o  = mem[rptr % 64];   // Show-ahead head word

endmodule

`default_nettype wire

//--- tests/qspim_if_properties.sv
`timescale 1ns/1ns
`default_nettype none
// ----------------------------------------------------------------------
// Protocol rules on the top level, checked only out of reset
// ----------------------------------------------------------------------

module qspim_if_properties (
  input logic                       mclk,
  input logic                       rst_n,
  input logic                       wbd_ack_o,
  input qspim_pkg::qspim_word_t     wbd_adr_i,
  input logic                       cmd_fifo_wr_o,
  input qspim_pkg::qspim_cmd_word_t cmd_fifo_wdata_o,
  input logic                       res_fifo_rd_o,
  input logic                       spim_reg_req_o
);

  int fails = 0;   // Failed assertion count

  ack_single: assert property (@(posedge mclk) disable iff (!rst_n)
    wbd_ack_o |=> !wbd_ack_o)
    else begin
      $error("ack held two cycles");
      fails++;
    end

  // Flash word reaches the bus one cycle after its pop
  pop_then_ack: assert property (@(posedge mclk) disable iff (!rst_n)
    res_fifo_rd_o |=> wbd_ack_o)
    else begin
      $error("No bus acknowledge after response pop");
      fails++;
    end

  adr_follows: assert property (@(posedge mclk) disable iff (!rst_n)
    (cmd_fifo_wr_o && cmd_fifo_wdata_o[35]) |=>
      (cmd_fifo_wr_o && cmd_fifo_wdata_o[34] && cmd_fifo_wdata_o[31:0] == wbd_adr_i))
    else begin
      $error("No address word after first word");
      fails++;
    end

  reg_cmd_excl: assert property (@(posedge mclk) disable iff (!rst_n)
    !(spim_reg_req_o && cmd_fifo_wr_o))
    else begin
      $error("Register request during command");
      fails++;
    end

endmodule

bind qspim_if qspim_if_properties props_i (.*);

`default_nettype wire

//--- tests/qspim_if_tb.sv
`timescale 1ns/1ns
`default_nettype none
// ----------------------------------------------------------------------
// Table driven test of the wishbone front end, one bus cycle per row
// Register block model acks two cycles after its request
// ----------------------------------------------------------------------

module qspim_if_tb;

  localparam int NUM_ROWS = 9;
  localparam int OP_WR = 0, OP_RD = 1, OP_MEM = 2, OP_GATE = 3;

  typedef struct {
    int                         op;
    qspim_pkg::qspim_word_t     adr;
    qspim_pkg::qspim_word_t     wdat;
    qspim_pkg::qspim_data_cnt_t dcnt;
    qspim_pkg::qspim_cs_field_t mask;   // Same mask for every select
    qspim_pkg::qspim_word_t     exp;
    int                         ncmd;   // Command words expected
  } row_t;

  logic mclk = 0, rst_n = 0, wbd_stb_i = 0, wbd_we_i = 0, spi_init_done_i = 1;
  qspim_pkg::qspim_word_t wbd_adr_i = '0, wbd_dat_i = '0, wbd_dat_o, spim_reg_wdata_o;
  qspim_pkg::qspim_be_t wbd_sel_i = '0, spim_reg_be_o;
  qspim_pkg::qspim_cs_field_t cs_adr [qspim_pkg::NUM_CS] = '{8'h00, 8'h03, 8'h20, 8'h10};
  qspim_pkg::qspim_cs_field_t cs_msk [qspim_pkg::NUM_CS] = '{default: 8'hFF};
  qspim_pkg::qspim_data_cnt_t rows_dcnt = 8'd4;   // Data count of the current row
  logic wbd_ack_o, spim_reg_req_o, spim_reg_we_o, spim_reg_ack_i = 0, cmd_fifo_wr_o;
  logic res_fifo_rd_o, cmd_empty, res_empty;
  logic [qspim_pkg::NUM_CS-1:0] m0_cs_reg_o;
  qspim_pkg::qspim_reg_addr_t spim_reg_addr_o;
  qspim_pkg::qspim_word_t spim_reg_rdata_i = '0, res_head, regs [16], shadow [16];
  qspim_pkg::qspim_cmd_word_t cmd_fifo_wdata_o, first_word, adr_word;
  int cmd_cnt, cycles = 0, errors = 0, checks = 0, reg_dly = 0;
  row_t rows [NUM_ROWS];

  initial begin
    forever #2 mclk = ~mclk;
  end

  qspim_if qspim_if_i (
    .mclk, .rst_n, .wbd_stb_i, .wbd_adr_i, .wbd_we_i, .wbd_dat_i, .wbd_sel_i, .wbd_dat_o,
    .wbd_ack_o, .cfg_m0_cs_addr_i(cs_adr), .cfg_m0_cs_amask_i(cs_msk), .cfg_fsm_reset_i(1'b0),
    .cfg_mem_seq_i(qspim_pkg::SEQ_CAMDR), .cfg_addr_cnt_i(2'd2), .cfg_dummy_cnt_i(4'd6),
    .cfg_data_cnt_i(rows_dcnt), .cfg_cmd_reg_i(8'hEB), .cfg_mode_reg_i(8'hA0),
    .spi_init_done_i, .m0_cs_reg_o, .spim_reg_req_o, .spim_reg_addr_o, .spim_reg_we_o,
    .spim_reg_be_o, .spim_reg_wdata_o, .spim_reg_ack_i, .spim_reg_rdata_i,
    .cmd_fifo_empty_i(cmd_empty), .cmd_fifo_wr_o, .cmd_fifo_wdata_o,
    .res_fifo_empty_i(res_empty), .res_fifo_rd_o, .res_fifo_rdata_i(res_head)
  );

  qspim_fifo_model fifo_i (
    .mclk,
    .cmd_wr_i     (cmd_fifo_wr_o),
    .cmd_wdata_i  (cmd_fifo_wdata_o),
    .res_rd_i     (res_fifo_rd_o),
    .cmd_empty_o  (cmd_empty),
    .res_empty_o  (res_empty),
    .res_head_o   (res_head),
    .cmd_cnt_o    (cmd_cnt),
    .first_word_o (first_word),
    .adr_word_o   (adr_word)
  );

  // Register block, ack two cycles after the request
  always @(posedge mclk) begin
    spim_reg_ack_i <= 1'b0;
    if (spim_reg_req_o && !spim_reg_ack_i) begin
      reg_dly <= reg_dly + 1;
      if (reg_dly == 1) begin
        spim_reg_ack_i <= 1'b1;
        reg_dly        <= 0;
        if (spim_reg_we_o) regs[spim_reg_addr_o] <= spim_reg_wdata_o;
        spim_reg_rdata_i <= regs[spim_reg_addr_o];
      end
    end
  end

  always @(posedge mclk) begin
    cycles <= cycles + 1;
    if (cycles > 200 * NUM_ROWS) begin
      $display("Timeout, no acknowledge after %0d cycles", cycles);
      $display("CHECKS FAILED");
      $finish;
    end
  end

  task automatic word_equal(input string name, input qspim_pkg::qspim_word_t got, exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("CHECK FAILED %s got %h expected %h", name, got, exp);
    end
  endtask

  task automatic cmd_equal(input string name, input qspim_pkg::qspim_cmd_word_t got, exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("CHECK FAILED %s got %h expected %h", name, got, exp);
    end
  endtask

  task automatic cs_equal(input string name, input logic [qspim_pkg::NUM_CS-1:0] got, exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("CHECK FAILED %s got %h expected %h", name, got, exp);
    end
  endtask

  task automatic bit_equal(input string name, input logic got, exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("CHECK FAILED %s got %h expected %h", name, got, exp);
    end
  endtask

  // Mask and compare rule over bits 27:20, same mask for each select
  function automatic logic [qspim_pkg::NUM_CS-1:0] cs_expect(
    input qspim_pkg::qspim_word_t     adr,
    input qspim_pkg::qspim_cs_field_t mask
  );
    logic [qspim_pkg::NUM_CS-1:0] cs;
    for (int i = 0; i < qspim_pkg::NUM_CS; i++) cs[i] = ((adr[27:20] & mask) == cs_adr[i]);
    return cs;
  endfunction

  task automatic run_row(input row_t r, input int idx);
    int n0, waited, err0;
    logic done;
    qspim_pkg::qspim_be_t sel;
    qspim_pkg::qspim_word_t rdat;
    qspim_pkg::qspim_cmd_word_t exp_first;
    n0 = cmd_cnt;
    err0 = errors;
    waited = 0;
    done = 0;
    sel = 4'hF >> (idx % 4);   // Byte enables differ from row to row
    @(negedge mclk);
    cs_msk = '{default: r.mask};
    rows_dcnt = r.dcnt;
    spi_init_done_i = (r.op != OP_GATE);
    wbd_stb_i = 1;
    wbd_adr_i = r.adr;
    wbd_we_i = (r.op == OP_WR);
    wbd_dat_i = r.wdat;
    wbd_sel_i = sel;
    while (!done) begin
      @(negedge mclk);
      waited++;
      if (waited == 1) begin
        // Only a captured register window request reaches the block
        bit_equal("spim_reg_req_o", spim_reg_req_o, r.op == OP_WR || r.op == OP_RD);
      end
      if (waited == 1 && r.op <= OP_RD) begin
        bit_equal("spim_reg_we_o", spim_reg_we_o, r.op == OP_WR);
        word_equal("spim_reg_addr_o", 32'(spim_reg_addr_o), 32'(r.adr[5:2]));
      end
      if (waited == 1 && r.op == OP_WR) begin
        word_equal("spim_reg_be_o", 32'(spim_reg_be_o), 32'(sel));
        word_equal("spim_reg_wdata_o", spim_reg_wdata_o, r.wdat);
      end
      if (!spi_init_done_i && wbd_ack_o) begin
        errors++;
        $display("Acknowledge came while init was not done");
      end
      if (!spi_init_done_i && waited >= 20) spi_init_done_i = 1;
      done = wbd_ack_o;
    end
    rdat = wbd_dat_o;
    wbd_stb_i = 0;
    if (r.op == OP_WR) shadow[r.adr[5:2]] = r.wdat;
    if (r.op == OP_RD) word_equal("wbd_dat_o", rdat, shadow[r.adr[5:2]]);
    if (r.op >= OP_MEM) begin
      word_equal("wbd_dat_o", rdat, r.exp);
      cs_equal("m0_cs_reg_o", m0_cs_reg_o, cs_expect(r.adr, r.mask));
      if (cmd_cnt - n0 != r.ncmd) begin
        errors++;
        $display("Row %0d wrote %0d command words, expected %0d", idx, cmd_cnt - n0, r.ncmd);
      end
      if (r.ncmd == 2) begin
        exp_first = {1'b1, 1'b0, r.dcnt, 4'd6, 2'd2, qspim_pkg::SEQ_CAMDR, 8'hA0, 8'hEB};
        cmd_equal("first command word", first_word, exp_first);
        cmd_equal("address command word", adr_word, {4'b0100, r.adr});
      end
    end
    $display("Row %0d op %0d adr %h %s", idx, r.op, r.adr, (errors == err0) ? "ok" : "failed");
  endtask

  initial begin
    void'($urandom(56));
    rows[0] = '{OP_WR,   32'h1000_0014, $urandom, 8'd4, 8'hFF, 32'h0, 0};
    rows[1] = '{OP_WR,   32'h1000_0008, $urandom, 8'd4, 8'hFF, 32'h0, 0};
    rows[2] = '{OP_RD,   32'h1000_0014, 32'h0,    8'd4, 8'hFF, 32'h0, 0};
    rows[3] = '{OP_RD,   32'h1000_0008, 32'h0,    8'd4, 8'hFF, 32'h0, 0};
    rows[4] = '{OP_MEM,  32'h0010_0040, 32'h0,    8'd4, 8'hF0, 32'h5A4A_0040, 2};
    rows[5] = '{OP_MEM,  32'h0020_0100, 32'h0,    8'd8, 8'hF0, 32'h5A7A_0100, 2};
    rows[6] = '{OP_MEM,  32'h0020_0104, 32'h0,    8'd8, 8'hFF, 32'h5A7A_0104, 0};  // Hit
    rows[7] = '{OP_MEM,  32'h0030_0200, 32'h0,    8'd4, 8'h0F, 32'h5A6A_0200, 2};
    rows[8] = '{OP_GATE, 32'h0100_0000, 32'h0,    8'd4, 8'hFF, 32'h5B5A_0000, 2};
    repeat (4) @(posedge mclk);
    @(negedge mclk);
    rst_n = 1;
    for (int i = 0; i < NUM_ROWS; i++) run_row(rows[i], i);
    repeat (4) @(negedge mclk);
    errors = errors + qspim_if_i.props_i.fails;   // Bound assertion failures
    $display("%0d rows, %0d checks, %0d errors", NUM_ROWS, checks, errors);
    if (errors == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- filelist.f
source/qspim_pkg.sv
source/qspim_wb_front.sv
source/qspim_cs_decode.sv
source/qspim_read_fsm.sv
source/qspim_prefetch_track.sv
source/qspim_if.sv
tests/qspim_fifo_model.sv
tests/qspim_if_properties.sv
tests/qspim_if_tb.sv
